/* src/upsp_params.svh */
// Up-sampler output path sizing: pixel format, word packing, frame geometry and buffer depth
`ifndef UPSP_PARAMS_SVH
`define UPSP_PARAMS_SVH

// RGB888 pixel
`define UPSP_PIXEL_BITS 24

// Pixels packed in one upsampler word and in one output beat
`define UPSP_PIX_PER_WORD 4
`define UPSP_WORD_BITS (`UPSP_PIXEL_BITS * `UPSP_PIX_PER_WORD)

// Destination image size in pixels and rows
`define UPSP_DST_WIDTH 32
`define UPSP_DST_HEIGHT 4

// Derived beat counts
`define UPSP_BEATS_PER_ROW (`UPSP_DST_WIDTH / `UPSP_PIX_PER_WORD)
`define UPSP_BEATS_PER_FRAME (`UPSP_BEATS_PER_ROW * `UPSP_DST_HEIGHT)

// Output buffer depth in words, a power of two
`define UPSP_OBUF_DEPTH 8

`endif

/* src/upsp_pkg.sv */
// Shared types of the up-sampler output path: pixel and word vectors, counters, status, FSM states
`include "upsp_params.svh"

package upsp_pkg;

	// One RGB pixel
	typedef logic [`UPSP_PIXEL_BITS-1:0] pixel_t;

	// One upsampler word, also one AXI-Stream beat
	typedef logic [`UPSP_WORD_BITS-1:0] word_t;

	// Beat index within a frame, wide enough to hold the full frame count
	typedef logic [$clog2(`UPSP_BEATS_PER_FRAME + 1)-1:0] beat_cnt_t;

	// Register file status: bit 1 is end, bit 0 is start
	typedef logic [1:0] status_t;

	// Session FSM
	typedef enum logic [1:0] {
		IDLE     = 2'd0,
		RUN      = 2'd1,
		FINISH   = 2'd2,
		WAIT_ACK = 2'd3
	} session_state_t;

endpackage

/* src/session_fsm.sv */
// Session FSM: opens the operating window per frame and writes start/end status back
`timescale 1ns/1ps
`include "upsp_params.svh"

module session_fsm (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              up_start,
	input  logic              up_end,
	input  logic              frame_done,
	output logic              window,
	output logic              processing,
	output logic              status_wr,
	output upsp_pkg::status_t status_wdata
);

	import upsp_pkg::*;

	session_state_t state;

	// Upsampler may only write while the frame is running
	assign window = (state == RUN);

	// Busy from frame start until the register file acknowledges the end
	assign processing = (state != IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= IDLE;
			status_wr    <= 1'b0;
			status_wdata <= '0;
		end else begin
			// Write strobe is a single-cycle pulse by default
			status_wr <= 1'b0;
			case (state)
				IDLE: begin
					// New frame requested and previous end already cleared
					if (up_start && !up_end) begin
						state <= RUN;
					end
				end
				RUN: begin
					// Whole frame sent, clear start and keep end as it is
					if (frame_done) begin
						status_wr    <= 1'b1;
						status_wdata <= {up_end, 1'b0};
						state        <= FINISH;
					end
				end
				FINISH: begin
					// Wait until the register file has taken the start clear
					if (!up_start) begin
						if (!up_end) begin
							// Now raise end
							status_wr    <= 1'b1;
							status_wdata <= {1'b1, 1'b0};
							state        <= WAIT_ACK;
						end else begin
							// End was already set, nothing left to write
							state <= IDLE;
						end
					end
				end
				WAIT_ACK: begin
					if (!up_start && up_end) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Register file needs a gap between the two write-backs
	a_status_wr_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		status_wr |=> !status_wr
	) else $error("status_wr held high for two cycles");

	// Start clear is always followed by an end set before going idle
	a_end_after_start_clear: assert property (
		@(posedge clk) disable iff (!rst_n)
		(status_wr && !status_wdata[1]) |=> (state != IDLE) until_with
			(status_wr && status_wdata == {1'b1, 1'b0})
	) else $error("end write missing after start clear");

endmodule

/* src/frame_counter.sv */
// Frame beat counter: tracks popped beats, marks row ends and detects frame completion
`timescale 1ns/1ps
`include "upsp_params.svh"

module frame_counter (
	input  logic clk,
	input  logic rst_n,
	input  logic pop,
	input  logic sent,
	output logic row_end,
	output logic frame_done
);

	import upsp_pkg::*;

	beat_cnt_t cnt;
	logic      last_sent;

	// Count reaches frame size once the final beat has been popped,
	// so the next handshake is the last beat leaving
	assign last_sent = sent && (cnt == `UPSP_BEATS_PER_FRAME);

	// Next popped beat closes a destination row
	assign row_end = ((cnt % `UPSP_BEATS_PER_ROW) == (`UPSP_BEATS_PER_ROW - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (last_sent) begin
			cnt <= '0;
		end else if (pop) begin
			cnt <= cnt + 1'b1;
		end
	end

	// One-cycle completion pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_done <= 1'b0;
		end else begin
			frame_done <= last_sent;
		end
	end

	// Upsampler must not deliver more words than one frame holds
	a_no_overrun: assert property (
		@(posedge clk) disable iff (!rst_n)
		pop |-> (cnt < `UPSP_BEATS_PER_FRAME)
	) else $error("beat count above frame size");

endmodule

/* src/pixel_outbuf.sv */
// Output buffer: FIFO of upsampler words, written only inside the window, flushed at frame end
`timescale 1ns/1ps
`include "upsp_params.svh"

module pixel_outbuf (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            window,
	input  logic            frame_done,
	input  logic            wvalid,
	output logic            wready,
	input  upsp_pkg::word_t wdata,
	input  logic            pop,
	output logic            empty,
	output upsp_pkg::word_t rdata
);

	import upsp_pkg::*;

	localparam int AW = $clog2(`UPSP_OBUF_DEPTH);

	word_t mem [`UPSP_OBUF_DEPTH];

	// Extra MSB tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        full;
	logic        push;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// Accept only during the operating window
	assign wready = window && !full;
	assign push   = wvalid && wready;

	// Head of queue is read straight from the array
	assign rdata = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr[AW-1:0]] <= wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (frame_done) begin
			// Drop anything left over from the finished frame
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Output stage only pops a non-empty buffer
	a_no_pop_empty: assert property (
		@(posedge clk) disable iff (!rst_n)
		pop |-> !empty
	) else $error("pop on empty buffer");

	// Fill level stays within depth, so no write landed on a full buffer
	a_no_push_full: assert property (
		@(posedge clk) disable iff (!rst_n)
		(wr_ptr - rd_ptr) <= (AW + 1)'(`UPSP_OBUF_DEPTH)
	) else $error("buffer overflow");

endmodule

/* src/axis_out_stage.sv */
// AXI-Stream master register: pops the buffer, reverses pixel order, marks row ends
`timescale 1ns/1ps
`include "upsp_params.svh"

module axis_out_stage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            window,
	input  logic            empty,
	input  upsp_pkg::word_t rdata,
	input  logic            row_end,
	output logic            pop,
	output logic            sent,
	output logic            tvalid,
	input  logic            tready,
	output upsp_pkg::word_t tdata,
	output logic            tlast
);

	import upsp_pkg::*;

	// First pixel of the word goes to the top of the beat
	function automatic word_t reverse_pixels(input word_t w);
		word_t  r;
		pixel_t p;
		for (int i = 0; i < `UPSP_PIX_PER_WORD; i++) begin
			p = w[(`UPSP_PIX_PER_WORD - 1 - i) * `UPSP_PIXEL_BITS +: `UPSP_PIXEL_BITS];
			r[i * `UPSP_PIXEL_BITS +: `UPSP_PIXEL_BITS] = p;
		end
		return r;
	endfunction

	assign sent = tvalid && tready;

	// Refill when the register is free or its beat leaves this cycle
	assign pop = window && !empty && (!tvalid || tready);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tvalid <= 1'b0;
			tlast  <= 1'b0;
		end else if (pop) begin
			tvalid <= 1'b1;
			tlast  <= row_end;
		end else if (tready) begin
			tvalid <= 1'b0;
			tlast  <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			tdata <= reverse_pixels(rdata);
		end
	end

	// Beat must not change while the sink stalls
	a_hold_on_stall: assert property (
		@(posedge clk) disable iff (!rst_n)
		(tvalid && !tready) |=> (tvalid && $stable(tdata) && $stable(tlast))
	) else $error("tdata/tlast changed under back-pressure");

endmodule

/* src/access_top.sv */
// Access controller output path: session FSM, frame counter, output buffer and AXI-Stream master
`timescale 1ns/1ps
`include "upsp_params.svh"

module access_top (
	input  logic              clk,
	input  logic              rst_n,

	// Configuration register file
	input  logic              up_start,
	input  logic              up_end,
	output logic              status_wr,
	output upsp_pkg::status_t status_wdata,
	output logic              processing,

	// Upsampler write port
	input  logic              upsp_wvalid,
	output logic              upsp_wready,
	input  upsp_pkg::word_t   upsp_wdata,

	// AXI-Stream master
	output logic              m_axis_tvalid,
	input  logic              m_axis_tready,
	output upsp_pkg::word_t   m_axis_tdata,
	output logic              m_axis_tlast
);

	import upsp_pkg::*;

	logic  window;
	logic  frame_done;
	logic  pop;
	logic  sent;
	logic  empty;
	logic  row_end;
	word_t rdata;

	session_fsm u_session_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.up_start     (up_start),
		.up_end       (up_end),
		.frame_done   (frame_done),
		.window       (window),
		.processing   (processing),
		.status_wr    (status_wr),
		.status_wdata (status_wdata)
	);

	// Completion is taken from our own output handshake
	frame_counter u_frame_counter (
		.clk        (clk),
		.rst_n      (rst_n),
		.pop        (pop),
		.sent       (sent),
		.row_end    (row_end),
		.frame_done (frame_done)
	);

	pixel_outbuf u_pixel_outbuf (
		.clk        (clk),
		.rst_n      (rst_n),
		.window     (window),
		.frame_done (frame_done),
		.wvalid     (upsp_wvalid),
		.wready     (upsp_wready),
		.wdata      (upsp_wdata),
		.pop        (pop),
		.empty      (empty),
		.rdata      (rdata)
	);

	axis_out_stage u_axis_out_stage (
		.clk     (clk),
		.rst_n   (rst_n),
		.window  (window),
		.empty   (empty),
		.rdata   (rdata),
		.row_end (row_end),
		.pop     (pop),
		.sent    (sent),
		.tvalid  (m_axis_tvalid),
		.tready  (m_axis_tready),
		.tdata   (m_axis_tdata),
		.tlast   (m_axis_tlast)
	);

endmodule

/* testbench/tb_access_top.sv */
// Testbench for the access controller output path: random upsampler and sink, register-file model
`timescale 1ns/1ps
`include "upsp_params.svh"

module tb_access_top;

	import upsp_pkg::*;

	localparam int FRAMES  = 2;
	localparam int TIMEOUT = 4000;

	logic    clk           = 1'b0;
	logic    rst_n         = 1'b0;
	logic    up_start      = 1'b0;
	logic    up_end        = 1'b0;
	logic    upsp_wvalid   = 1'b0;
	word_t   upsp_wdata    = '0;
	logic    m_axis_tready = 1'b0;
	logic    status_wr;
	status_t status_wdata;
	logic    processing;
	logic    upsp_wready;
	logic    m_axis_tvalid;
	word_t   m_axis_tdata;
	logic    m_axis_tlast;

	// Requests from the frame sequence to the register-file model
	logic set_start = 1'b0;
	logic clear_end = 1'b0;

	logic [31:0] seed = 32'hd531;
	word_t       ref_q[$];
	int          errors      = 0;
	int          words_in    = 0;
	int          total_words = 0;
	int          frame_beats = 0;
	int          total_beats = 0;
	logic        timed_out   = 1'b0;

	// Previous-cycle view of the output for the stall check
	logic  stalled   = 1'b0;
	word_t held_data = '0;
	logic  held_last = 1'b0;

	access_top u_access_top (
		.clk           (clk),
		.rst_n         (rst_n),
		.up_start      (up_start),
		.up_end        (up_end),
		.status_wr     (status_wr),
		.status_wdata  (status_wdata),
		.processing    (processing),
		.upsp_wvalid   (upsp_wvalid),
		.upsp_wready   (upsp_wready),
		.upsp_wdata    (upsp_wdata),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tlast  (m_axis_tlast)
	);

	always #10 clk = ~clk;

	// LCG step, upper bits are the better random ones
	function automatic logic [31:0] draw();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Shift pixels in from the low end so pixel 0 lands on top
	function automatic word_t flip_order(input word_t w);
		word_t out;
		out = '0;
		for (int i = 0; i < `UPSP_PIX_PER_WORD; i++) begin
			out = {out[`UPSP_WORD_BITS-`UPSP_PIXEL_BITS-1:0],
				w[i*`UPSP_PIXEL_BITS +: `UPSP_PIXEL_BITS]};
		end
		return out;
	endfunction

	task automatic finish_run();
		$display("Words accepted: %0d, beats sent: %0d, errors: %0d",
			total_words, total_beats, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("Timeout while waiting for %s", what);
	endtask

	// Register file: a status write lands on the next edge
	always @(posedge clk) begin
		if (status_wr) begin
			up_start <= status_wdata[0];
			up_end   <= status_wdata[1];
		end else begin
			if (set_start) begin
				up_start <= 1'b1;
			end
			if (clear_end) begin
				up_end <= 1'b0;
			end
		end
	end

	// Upsampler and sink stimulus, one frame worth of words per session
	always @(posedge clk) begin : stimulus
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		if (rst_n) begin
			r0 = draw();
			m_axis_tready <= (r0[17:16] != 2'b00);
			if (upsp_wvalid && upsp_wready) begin
				ref_q.push_back(flip_order(upsp_wdata));
				words_in++;
				total_words++;
			end
			if (!processing) begin
				words_in = 0;
			end
			if (upsp_wvalid && !upsp_wready) begin
				// Word held until the buffer takes it
			end else if (words_in < `UPSP_BEATS_PER_FRAME && r0[21]) begin
				r1 = draw();
				r2 = draw();
				r3 = draw();
				upsp_wvalid <= 1'b1;
				upsp_wdata  <= {r1, r2, r3};
			end else begin
				upsp_wvalid <= 1'b0;
			end
		end
	end

	// Output checker
	always @(posedge clk) begin : monitor
		word_t exp_data;
		logic  exp_last;
		if (rst_n) begin
			if (stalled) begin
				if (!m_axis_tvalid) begin
					errors++;
					$display("Fail m_axis_tvalid: got %h, expected %h", m_axis_tvalid, 1'b1);
				end
				if (m_axis_tdata !== held_data) begin
					errors++;
					$display("Fail m_axis_tdata: got %h, expected %h", m_axis_tdata, held_data);
				end
				if (m_axis_tlast !== held_last) begin
					errors++;
					$display("Fail m_axis_tlast: got %h, expected %h", m_axis_tlast, held_last);
				end
			end
			if (m_axis_tvalid && m_axis_tready) begin
				if (ref_q.size() == 0) begin
					errors++;
					$display("Beat sent with no accepted word pending");
				end else begin
					exp_data = ref_q.pop_front();
					if (m_axis_tdata !== exp_data) begin
						errors++;
						$display("Fail m_axis_tdata: got %h, expected %h", m_axis_tdata, exp_data);
					end
				end
				exp_last = (((frame_beats + 1) % `UPSP_BEATS_PER_ROW) == 0);
				if (m_axis_tlast !== exp_last) begin
					errors++;
					$display("Fail m_axis_tlast: got %h, expected %h", m_axis_tlast, exp_last);
				end
				frame_beats++;
				total_beats++;
			end
			// Start clear marks the end of a frame
			if (status_wr && status_wdata == 2'b00) begin
				if (frame_beats != `UPSP_BEATS_PER_FRAME) begin
					errors++;
					$display("Frame ended after %0d beats instead of %0d",
						frame_beats, `UPSP_BEATS_PER_FRAME);
				end
				if (ref_q.size() != 0) begin
					errors++;
					$display("%0d accepted words were never sent", ref_q.size());
				end
				frame_beats = 0;
			end
			if (upsp_wready && !up_start) begin
				errors++;
				$display("Upsampler write accepted while start is clear");
			end
			stalled   = m_axis_tvalid && !m_axis_tready;
			held_data = m_axis_tdata;
			held_last = m_axis_tlast;
		end
	end

	task automatic wait_processing(input logic level);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (processing !== level && n < TIMEOUT);
		if (processing !== level) begin
			report_timeout("processing to change");
		end
	endtask

	task automatic wait_status_write(output status_t d);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (status_wr !== 1'b1 && n < TIMEOUT);
		if (status_wr !== 1'b1) begin
			report_timeout("a status write");
		end
		d = status_wdata;
	endtask

	task automatic run_frame();
		status_t d;
		set_start <= 1'b1;
		clear_end <= 1'b1;
		@(posedge clk);
		set_start <= 1'b0;
		clear_end <= 1'b0;
		wait_processing(1'b1);
		if (!timed_out) begin
			wait_status_write(d);
		end
		if (!timed_out && d !== 2'b00) begin
			errors++;
			$display("Fail status_wdata: got %h, expected %h", d, 2'b00);
		end
		if (!timed_out) begin
			wait_status_write(d);
		end
		if (!timed_out && d !== 2'b10) begin
			errors++;
			$display("Fail status_wdata: got %h, expected %h", d, 2'b10);
		end
		if (!timed_out) begin
			wait_processing(1'b0);
		end
		if (!timed_out && (up_start !== 1'b0 || up_end !== 1'b1)) begin
			errors++;
			$display("processing fell before the register file showed start clear and end set");
		end
	endtask

	initial begin
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);
		// Idle outputs out of reset
		if (m_axis_tvalid !== 1'b0) begin
			errors++;
			$display("Fail m_axis_tvalid: got %h, expected %h", m_axis_tvalid, 1'b0);
		end
		if (status_wr !== 1'b0) begin
			errors++;
			$display("Fail status_wr: got %h, expected %h", status_wr, 1'b0);
		end
		if (processing !== 1'b0) begin
			errors++;
			$display("Fail processing: got %h, expected %h", processing, 1'b0);
		end
		if (upsp_wready !== 1'b0) begin
			errors++;
			$display("Fail upsp_wready: got %h, expected %h", upsp_wready, 1'b0);
		end
		for (int f = 0; f < FRAMES; f++) begin
			if (!timed_out) begin
				run_frame();
			end
		end
		if (!timed_out) begin
			repeat (4) @(posedge clk);
			if (total_beats != FRAMES * `UPSP_BEATS_PER_FRAME) begin
				errors++;
				$display("Sent %0d beats over all frames instead of %0d",
					total_beats, FRAMES * `UPSP_BEATS_PER_FRAME);
			end
		end
		finish_run();
	end

endmodule

/* project.f */
+incdir+src
src/upsp_pkg.sv
src/session_fsm.sv
src/frame_counter.sv
src/pixel_outbuf.sv
src/axis_out_stage.sv
src/access_top.sv
testbench/tb_access_top.sv
